// ==== lsu_pkg.sv ====
/*
 * lsu_pkg
 * shared widths, opcodes and bus records of the SIMD load/store unit
 */
`default_nettype none

package lsu_pkg;

    localparam int XLEN        = 32;
    localparam int WORD_ADDR_W = XLEN - 2;
    localparam int NW_WIDTH    = 2;
    localparam int NR_BITS     = 5;
    // lane count of all records below, lsu_top NUM_LANES has to match
    localparam int NUM_LANES   = 4;

    typedef enum logic [3:0] {
        LB, LH, LW, LBU, LHU, SB, SH, SW, FENCE
    } lsu_op_e;

    typedef logic [NUM_LANES-1:0][XLEN-1:0] lane_data_t;

    typedef struct packed {
        logic [NW_WIDTH-1:0]  wid;
        logic [NR_BITS-1:0]   rd;
        lsu_op_e              op;
        logic [NUM_LANES-1:0] tmask;
        lane_data_t           rs1;
        lane_data_t           rs2;
        logic [XLEN-1:0]      imm;
    } lsu_req_t;

    typedef struct packed {
        logic                                   rw;
        logic [NUM_LANES-1:0]                   mask;
        logic [NUM_LANES-1:0][WORD_ADDR_W-1:0]  addr;
        logic [NUM_LANES-1:0][3:0]              byteen;
        lane_data_t                             data;
    } mem_req_t;

    typedef struct packed {
        logic [NW_WIDTH-1:0]       wid;
        logic [NR_BITS-1:0]        rd;
        lsu_op_e                   op;
        logic [NUM_LANES-1:0]      tmask;
        logic [NUM_LANES-1:0][1:0] align;
    } load_meta_t;

    typedef struct packed {
        logic [NW_WIDTH-1:0]  wid;
        logic [NUM_LANES-1:0] tmask;
        logic [NR_BITS-1:0]   rd;
        logic                 wb;
        lane_data_t           data;
    } commit_t;

    // log2 of the access size in bytes
    function automatic logic [1:0] op_size(lsu_op_e op);
        case (op)
            LB, LBU, SB: return 2'd0;
            LH, LHU, SH: return 2'd1;
            default:     return 2'd2;
        endcase
    endfunction

    function automatic logic op_is_load(lsu_op_e op);
        return (op == LB) || (op == LH) || (op == LW) || (op == LBU) || (op == LHU);
    endfunction

    function automatic logic op_is_store(lsu_op_e op);
        return (op == SB) || (op == SH) || (op == SW);
    endfunction

endpackage

`default_nettype wire

// ==== lsu_addr_gen.sv ====
/*
 * lsu_addr_gen
 * per-lane address, byte enable and store data formation,
 * plus issue gating for loads, stores and fences
 */
`default_nettype none

module lsu_addr_gen (
    input  logic                req_valid,
    input  lsu_pkg::lsu_req_t   req,
    output logic                req_ready,
    output logic                mem_req_valid,
    input  logic                mem_req_ready,
    output lsu_pkg::mem_req_t   mem_req,
    input  logic                loadq_full,
    input  logic                loadq_empty,
    input  logic                store_slot_free,
    output logic                load_push,
    output lsu_pkg::load_meta_t load_meta,
    output logic                store_push
);
    import lsu_pkg::*;

    logic [NUM_LANES-1:0][XLEN-1:0] full_addr;
    logic is_load;
    logic is_store;
    logic is_fence;
    logic issue_ok;
    logic accept;

    assign is_load  = op_is_load(req.op);
    assign is_store = op_is_store(req.op);
    assign is_fence = (req.op == FENCE);

    // loads need a queue entry, stores need the commit slot
    assign issue_ok = is_load ? !loadq_full : (is_store && store_slot_free);

    assign mem_req_valid = req_valid && issue_ok;

    // fence holds until every outstanding load is answered
    assign req_ready = is_fence ? (loadq_empty && store_slot_free)
                                : (mem_req_ready && issue_ok);

    assign accept     = req_valid && req_ready;
    assign load_push  = accept && is_load;
    assign store_push = accept && (is_store || is_fence);

    always_comb begin
        mem_req.rw      = is_store;
        mem_req.mask    = req.tmask;
        load_meta.wid   = req.wid;
        load_meta.rd    = req.rd;
        load_meta.op    = req.op;
        load_meta.tmask = req.tmask;
        for (int i = 0; i < NUM_LANES; i++) begin
            full_addr[i]       = req.rs1[i] + req.imm;
            mem_req.addr[i]    = full_addr[i][XLEN-1:XLEN-WORD_ADDR_W];
            load_meta.align[i] = full_addr[i][1:0];
            case (op_size(req.op))
                2'd0:    mem_req.byteen[i] = 4'b0001 << full_addr[i][1:0];
                2'd1:    mem_req.byteen[i] = 4'b0011 << {full_addr[i][1], 1'b0};
                default: mem_req.byteen[i] = 4'b1111;
            endcase
            // move store data up to its byte lane
            mem_req.data[i] = req.rs2[i] << {full_addr[i][1:0], 3'b000};
        end
    end

endmodule

`default_nettype wire

// ==== lsu_load_queue.sv ====
/*
 * lsu_load_queue
 * in-order FIFO holding the metadata of loads waiting for data
 */
`default_nettype none

module lsu_load_queue #(
    parameter int LOADQ_DEPTH = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                push,
    input  lsu_pkg::load_meta_t push_meta,
    input  logic                pop,
    output lsu_pkg::load_meta_t head,
    output logic                full,
    output logic                empty
);
    import lsu_pkg::*;

    localparam int PTR_W = (LOADQ_DEPTH > 1) ? $clog2(LOADQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(LOADQ_DEPTH + 1);

    load_meta_t       entries [LOADQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // wrap explicitly so non power-of-two depths also work
    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(LOADQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_meta;
        end
    end

    assign head  = entries[rd_ptr];
    assign full  = (count == CNT_W'(LOADQ_DEPTH));
    assign empty = (count == '0);

endmodule

`default_nettype wire

// ==== lsu_load_format.sv ====
/*
 * lsu_load_format
 * picks the addressed byte, halfword or word of each lane
 * and sign- or zero-extends it
 */
`default_nettype none

module lsu_load_format (
    input  lsu_pkg::load_meta_t meta,
    input  lsu_pkg::lane_data_t rsp_data,
    output lsu_pkg::lane_data_t result
);
    import lsu_pkg::*;

    always_comb begin
        logic [15:0] half;
        logic [7:0]  byte_sel;
        for (int i = 0; i < NUM_LANES; i++) begin
            half     = meta.align[i][1] ? rsp_data[i][31:16] : rsp_data[i][15:0];
            byte_sel = meta.align[i][0] ? half[15:8] : half[7:0];
            case (meta.op)
                LB:      result[i] = {{(XLEN-8){byte_sel[7]}}, byte_sel};
                LH:      result[i] = {{(XLEN-16){half[15]}}, half};
                LBU:     result[i] = XLEN'(byte_sel);
                LHU:     result[i] = XLEN'(half);
                // word load
                default: result[i] = rsp_data[i];
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== lsu_commit.sv ====
/*
 * lsu_commit
 * store/fence and load commit slots merged onto one registered
 * commit port, alternating when both slots are full
 */
`default_nettype none

module lsu_commit (
    input  logic             clk,
    input  logic             reset,
    input  logic             store_push,
    input  lsu_pkg::commit_t store_rec,
    input  logic             load_push,
    input  lsu_pkg::commit_t load_rec,
    input  logic             commit_ready,
    output logic             store_slot_free,
    output logic             load_slot_free,
    output logic             commit_valid,
    output lsu_pkg::commit_t commit
);
    import lsu_pkg::*;

    commit_t st_rec;
    commit_t ld_rec;
    commit_t out_rec;
    logic    st_valid;
    logic    ld_valid;
    logic    out_valid;
    logic    last_store;
    logic    out_open;
    logic    take_store;
    logic    take_load;

    assign out_open = !out_valid || commit_ready;

    // round robin only matters when both slots hold a record
    assign take_store = out_open && st_valid && (!ld_valid || !last_store);
    assign take_load  = out_open && ld_valid && !take_store;

    always_ff @(posedge clk) begin
        if (reset) begin
            st_valid   <= 1'b0;
            ld_valid   <= 1'b0;
            out_valid  <= 1'b0;
            last_store <= 1'b0;
        end else begin
            if (store_push) begin
                st_valid <= 1'b1;
            end else if (take_store) begin
                st_valid <= 1'b0;
            end
            if (load_push) begin
                ld_valid <= 1'b1;
            end else if (take_load) begin
                ld_valid <= 1'b0;
            end
            if (take_store || take_load) begin
                out_valid  <= 1'b1;
                last_store <= take_store;
            end else if (commit_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store_push) begin
            st_rec <= store_rec;
        end
        if (load_push) begin
            ld_rec <= load_rec;
        end
        if (take_store) begin
            out_rec <= st_rec;
        end else if (take_load) begin
            out_rec <= ld_rec;
        end
    end

    assign store_slot_free = !st_valid;
    assign load_slot_free  = !ld_valid;
    assign commit_valid    = out_valid;
    assign commit          = out_rec;

endmodule

`default_nettype wire

// ==== lsu_top.sv ====
/*
 * lsu_top
 * load/store unit for one SIMD issue slot with an in-order data port
 */
`default_nettype none

module lsu_top #(
    parameter int NUM_LANES   = 4,
    parameter int LOADQ_DEPTH = 4
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  req_valid,
    output logic                                  req_ready,
    input  lsu_pkg::lsu_req_t                     req,
    output logic                                  mem_req_valid,
    input  logic                                  mem_req_ready,
    output lsu_pkg::mem_req_t                     mem_req,
    input  logic                                  mem_rsp_valid,
    output logic                                  mem_rsp_ready,
    input  logic [NUM_LANES-1:0][lsu_pkg::XLEN-1:0] mem_rsp_data,
    output logic                                  commit_valid,
    input  logic                                  commit_ready,
    output lsu_pkg::commit_t                      commit
);
    import lsu_pkg::*;

    logic       loadq_full;
    logic       loadq_empty;
    logic       store_slot_free;
    logic       load_slot_free;
    logic       load_push;
    logic       store_push;
    logic       rsp_fire;
    load_meta_t load_meta;
    load_meta_t loadq_head;
    lane_data_t ld_result;
    commit_t    store_rec;
    commit_t    load_rec;

    assign mem_rsp_ready = load_slot_free;
    assign rsp_fire      = mem_rsp_valid && load_slot_free;

    // stores and fences retire without write-back
    assign store_rec = '{wid: req.wid, tmask: req.tmask, rd: '0, wb: 1'b0, data: '0};
    assign load_rec  = '{wid: loadq_head.wid, tmask: loadq_head.tmask,
                         rd: loadq_head.rd, wb: 1'b1, data: ld_result};

    lsu_addr_gen addr_gen_inst (
        .req_valid       (req_valid),
        .req             (req),
        .req_ready       (req_ready),
        .mem_req_valid   (mem_req_valid),
        .mem_req_ready   (mem_req_ready),
        .mem_req         (mem_req),
        .loadq_full      (loadq_full),
        .loadq_empty     (loadq_empty),
        .store_slot_free (store_slot_free),
        .load_push       (load_push),
        .load_meta       (load_meta),
        .store_push      (store_push)
    );

    lsu_load_queue #(
        .LOADQ_DEPTH (LOADQ_DEPTH)
    ) load_queue_inst (
        .clk       (clk),
        .reset     (reset),
        .push      (load_push),
        .push_meta (load_meta),
        .pop       (rsp_fire),
        .head      (loadq_head),
        .full      (loadq_full),
        .empty     (loadq_empty)
    );

    lsu_load_format load_format_inst (
        .meta     (loadq_head),
        .rsp_data (mem_rsp_data),
        .result   (ld_result)
    );

    lsu_commit commit_inst (
        .clk             (clk),
        .reset           (reset),
        .store_push      (store_push),
        .store_rec       (store_rec),
        .load_push       (rsp_fire),
        .load_rec        (load_rec),
        .commit_ready    (commit_ready),
        .store_slot_free (store_slot_free),
        .load_slot_free  (load_slot_free),
        .commit_valid    (commit_valid),
        .commit          (commit)
    );

endmodule

`default_nettype wire

// ==== lsu_props.sv ====
/*
 * lsu_props
 * alignment, commit stability and reset checks bound into lsu_top
 */
`default_nettype none

module lsu_props (
    input logic              clk,
    input logic              reset,
    input logic              req_valid,
    input logic              req_ready,
    input lsu_pkg::lsu_req_t req,
    input logic              commit_valid,
    input logic              commit_ready,
    input lsu_pkg::commit_t  commit
);
    timeunit 1ns;
    timeprecision 1ps;
    import lsu_pkg::*;

    logic mem_access;

    function automatic logic lanes_aligned(lsu_req_t r);
        logic [XLEN-1:0] a;
        logic            ok;
        ok = 1'b1;
        for (int i = 0; i < NUM_LANES; i++) begin
            a = r.rs1[i] + r.imm;
            if (r.tmask[i]) begin
                case (r.op)
                    LH, LHU, SH: ok = ok && !a[0];
                    LW, SW:      ok = ok && (a[1:0] == 2'b00);
                    default:     ;
                endcase
            end
        end
        return ok;
    endfunction

    assign mem_access = req_valid && req_ready && (req.op != FENCE);

    aligned_access: assert property (@(posedge clk) disable iff (reset)
        mem_access |-> lanes_aligned(req))
        else $error("misaligned load or store accepted");

    commit_stable: assert property (@(posedge clk) disable iff (reset)
        (commit_valid && !commit_ready) |=> (commit_valid && $stable(commit)))
        else $error("commit record changed while stalled");

    reset_quiet: assert property (@(posedge clk) reset |=> !commit_valid)
        else $error("commit_valid high during reset");

endmodule

bind lsu_top lsu_props lsu_props_inst (
    .clk          (clk),
    .reset        (reset),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .req          (req),
    .commit_valid (commit_valid),
    .commit_ready (commit_ready),
    .commit       (commit)
);

`default_nettype wire

// ==== tb_clock.sv ====
/*
 * tb_clock
 * 20 ns testbench clock and a reset held for 5 cycles
 */
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // high for five rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== lsu_tb.sv ====
/*
 * lsu_tb
 * directed tests of lsu_top with an in-order memory model,
 * a commit scoreboard and random back-pressure
 */
`default_nettype none

module lsu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import lsu_pkg::*;

    localparam int MEM_WORDS = 256;
    localparam int TIMEOUT   = 500;

    logic       clk;
    logic       reset;
    logic       req_valid;
    logic       req_ready;
    lsu_req_t   req;
    logic       mem_req_valid;
    logic       mem_req_ready = 1'b0;
    mem_req_t   mem_req;
    logic       mem_rsp_valid = 1'b0;
    logic       mem_rsp_ready;
    lane_data_t mem_rsp_data = '0;
    logic       commit_valid;
    logic       commit_ready = 1'b0;
    commit_t    commit;

    logic [XLEN-1:0] mem [MEM_WORDS];
    lane_data_t      rd_fifo [$];
    commit_t         exp_ld_q [$];
    commit_t         exp_st_q [$];
    int              exp_st_min [$];
    int              errors;
    int              checks;
    int              tests;
    int              test_start_errors;
    int              loads_accepted;
    int              loads_answered;
    int              loads_committed;
    int              taken_cnt;
    int              sent_cnt;
    int              delay_cnt;
    logic            rand_mode;
    logic            hold_rsp;

    tb_clock clock_inst (
        .clk   (clk),
        .reset (reset)
    );

    lsu_top #(
        .NUM_LANES   (NUM_LANES),
        .LOADQ_DEPTH (4)
    ) lsu_top_inst (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req           (req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .mem_rsp_data  (mem_rsp_data),
        .commit_valid  (commit_valid),
        .commit_ready  (commit_ready),
        .commit        (commit)
    );

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("%s at %0t", what, $time);
    endtask

    function automatic logic [XLEN-1:0] fill_word(int addr);
        return (32'(addr) * 32'h0101_0101) ^ 32'h5ac3_961e;
    endfunction

    function automatic logic is_store_op(lsu_op_e op);
        case (op)
            SB, SH, SW: return 1'b1;
            default:    return 1'b0;
        endcase
    endfunction

    function automatic logic [3:0] expected_byteen(lsu_op_e op, logic [1:0] align);
        case (op)
            LB, LBU, SB: return 4'b0001 << align;
            LH, LHU, SH: return align[1] ? 4'b1100 : 4'b0011;
            default:     return 4'b1111;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] expected_load(lsu_op_e op, logic [XLEN-1:0] word,
                                                      logic [1:0] align);
        logic [7:0]  b;
        logic [15:0] h;
        case (align)
            2'd0:    b = word[7:0];
            2'd1:    b = word[15:8];
            2'd2:    b = word[23:16];
            default: b = word[31:24];
        endcase
        h = align[1] ? word[31:16] : word[15:0];
        case (op)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'h0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'h0, h};
            default: return word;
        endcase
    endfunction

    function automatic logic [1:0] legal_offset(lsu_op_e op, logic [1:0] raw);
        case (op)
            LH, LHU, SH: return {raw[1], 1'b0};
            LW, SW:      return 2'b00;
            default:     return raw;
        endcase
    endfunction

    // bookkeeping on the acceptance edge of an instruction
    task automatic record_issue();
        commit_t         want;
        lane_data_t      rdata;
        logic [XLEN-1:0] addr;
        logic [1:0]      align;
        logic [7:0]      idx;
        logic            store;
        want       = '0;
        want.wid   = req.wid;
        want.tmask = req.tmask;
        rdata      = '0;
        store      = is_store_op(req.op);
        if (req.op == FENCE) begin
            check_value("mem_req_valid", 0, 32'(mem_req_valid));
            if (loads_accepted != loads_answered) begin
                report_failure("fence accepted while loads were outstanding");
            end
            exp_st_q.push_back(want);
            exp_st_min.push_back(loads_accepted);
        end else begin
            check_value("mem_req_valid", 1, 32'(mem_req_valid));
            check_value("mem_req.rw", 32'(store), 32'(mem_req.rw));
            check_value("mem_req.mask", 32'(req.tmask), 32'(mem_req.mask));
            for (int i = 0; i < NUM_LANES; i++) begin
                addr  = req.rs1[i] + req.imm;
                align = addr[1:0];
                idx   = addr[9:2];
                check_value($sformatf("mem_req.addr[%0d]", i), 32'(addr[XLEN-1:2]),
                            32'(mem_req.addr[i]));
                check_value($sformatf("mem_req.byteen[%0d]", i),
                            32'(expected_byteen(req.op, align)), 32'(mem_req.byteen[i]));
                if (store) begin
                    check_value($sformatf("mem_req.data[%0d]", i), req.rs2[i] << (8 * align),
                                mem_req.data[i]);
                    for (int b = 0; b < 4; b++) begin
                        if (req.tmask[i] && mem_req.byteen[i][b]) begin
                            mem[idx][8*b +: 8] = mem_req.data[i][8*b +: 8];
                        end
                    end
                end else begin
                    rdata[i] = mem[idx];
                    if (req.tmask[i]) begin
                        want.data[i] = expected_load(req.op, mem[idx], align);
                    end
                end
            end
            if (store) begin
                exp_st_q.push_back(want);
                exp_st_min.push_back(0);
            end else begin
                want.rd = req.rd;
                want.wb = 1'b1;
                exp_ld_q.push_back(want);
                rd_fifo.push_back(rdata);
                loads_accepted++;
            end
        end
    endtask

    task automatic check_commit();
        commit_t want;
        int      min_loads;
        if (commit.wb && exp_ld_q.size() == 0) begin
            report_failure("load commit with no load outstanding");
        end else if (!commit.wb && exp_st_q.size() == 0) begin
            report_failure("store commit with no store or fence outstanding");
        end else begin
            if (commit.wb) begin
                want = exp_ld_q.pop_front();
                loads_committed++;
                min_loads = 0;
            end else begin
                want = exp_st_q.pop_front();
                min_loads = exp_st_min.pop_front();
            end
            if (loads_committed < min_loads) begin
                report_failure("fence committed ahead of an earlier load");
            end
            check_value("commit.wid", 32'(want.wid), 32'(commit.wid));
            check_value("commit.tmask", 32'(want.tmask), 32'(commit.tmask));
            check_value("commit.rd", 32'(want.rd), 32'(commit.rd));
            check_value("commit.wb", 32'(want.wb), 32'(commit.wb));
            for (int i = 0; i < NUM_LANES; i++) begin
                if (want.tmask[i]) begin
                    check_value($sformatf("commit.data[%0d]", i), want.data[i], commit.data[i]);
                end
            end
        end
    endtask

    // memory model and scoreboard
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] = fill_word(i);
            end
        end else begin
            if (mem_rsp_valid && mem_rsp_ready) begin
                void'(rd_fifo.pop_front());
                taken_cnt++;
                loads_answered++;
            end
            if (mem_req_valid && mem_req_ready && !(req_valid && req_ready)) begin
                report_failure("memory request without an accepted instruction");
            end
            if (req_valid && req_ready) begin
                record_issue();
            end
            if (commit_valid && commit_ready) begin
                check_commit();
            end
        end
    end

    // ready randomization and the read responder
    always @(negedge clk) begin
        mem_req_ready = rand_mode ? ($urandom_range(0, 3) != 0) : 1'b1;
        commit_ready  = rand_mode ? ($urandom_range(0, 3) != 0) : 1'b1;
        if (mem_rsp_valid && taken_cnt == sent_cnt) begin
            mem_rsp_valid = 1'b0;
        end
        if (!mem_rsp_valid && !hold_rsp && rd_fifo.size() > 0) begin
            if (delay_cnt > 0) begin
                delay_cnt--;
            end else begin
                mem_rsp_valid = 1'b1;
                mem_rsp_data  = rd_fifo[0];
                sent_cnt++;
                delay_cnt = rand_mode ? int'($urandom_range(0, 3)) : 0;
            end
        end
    end

    task automatic wait_accept();
        int n;
        n = 0;
        @(posedge clk);
        while (!req_ready && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (!req_ready) begin
            report_failure("timeout waiting for req_ready");
        end
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic issue_instr(input lsu_op_e op, input logic [NUM_LANES-1:0] tmask,
                               input logic [NR_BITS-1:0] rd, input logic [1:0] offset);
        req.wid   = NW_WIDTH'($urandom);
        req.rd    = rd;
        req.op    = op;
        req.tmask = tmask;
        req.imm   = 32'h40;
        for (int i = 0; i < NUM_LANES; i++) begin
            req.rs1[i] = 32'(i * 128) + 32'($urandom_range(0, 15) * 4) + 32'(offset);
            req.rs2[i] = $urandom;
        end
        req_valid = 1'b1;
        wait_accept();
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while ((exp_ld_q.size() != 0 || exp_st_q.size() != 0) && n < 4 * TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (exp_ld_q.size() != 0 || exp_st_q.size() != 0) begin
            report_failure("timeout waiting for outstanding commits");
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %-14s %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    task automatic test_reset_idle();
        for (int n = 0; n < 5; n++) begin
            @(posedge clk);
            check_value("commit_valid", 0, 32'(commit_valid));
            check_value("mem_req_valid", 0, 32'(mem_req_valid));
        end
        @(negedge clk);
        end_test("reset_idle");
    endtask

    task automatic test_stores();
        for (int off = 0; off < 4; off++) begin
            issue_instr(SB, '1, 5'(off), 2'(off));
        end
        for (int off = 0; off < 4; off += 2) begin
            issue_instr(SH, '1, 5'(off), 2'(off));
        end
        issue_instr(SW, '1, 5'd7, 2'd0);
        wait_idle();
        end_test("stores");
    endtask

    task automatic test_loads();
        for (int off = 0; off < 4; off++) begin
            issue_instr(LB, '1, 5'(1 + off), 2'(off));
            issue_instr(LBU, '1, 5'(5 + off), 2'(off));
        end
        for (int off = 0; off < 4; off += 2) begin
            issue_instr(LH, '1, 5'(9 + off), 2'(off));
            issue_instr(LHU, '1, 5'(13 + off), 2'(off));
        end
        issue_instr(LW, '1, 5'd31, 2'd0);
        wait_idle();
        end_test("loads");
    endtask

    task automatic test_partial_masks();
        logic [NUM_LANES-1:0] m;
        for (int k = 0; k < 6; k++) begin
            m = NUM_LANES'($urandom_range(1, (1 << NUM_LANES) - 2));
            issue_instr(SW, m, 5'd0, 2'd0);
            issue_instr(LW, m, 5'(20 + k), 2'd0);
            issue_instr(LH, m, 5'(26 + k), 2'd2);
        end
        wait_idle();
        end_test("partial_masks");
    endtask

    task automatic test_backpressure();
        lsu_op_e op;
        rand_mode = 1'b1;
        for (int k = 0; k < 40; k++) begin
            op = lsu_op_e'(4'($urandom_range(0, 7)));
            issue_instr(op, NUM_LANES'($urandom_range(1, (1 << NUM_LANES) - 1)),
                        NR_BITS'($urandom), legal_offset(op, 2'($urandom)));
        end
        wait_idle();
        rand_mode = 1'b0;
        end_test("backpressure");
    endtask

    task automatic test_fence();
        logic accepted;
        hold_rsp = 1'b1;
        for (int k = 0; k < 3; k++) begin
            issue_instr(LW, '1, 5'(10 + k), 2'd0);
        end
        req.op    = FENCE;
        req.tmask = '1;
        req.rd    = 5'd0;
        req.wid   = 2'd1;
        req_valid = 1'b1;
        accepted  = 1'b0;
        // fence has to wait while responses are withheld
        for (int n = 0; n < 8 && !accepted; n++) begin
            @(posedge clk);
            accepted = req_ready;
        end
        @(negedge clk);
        if (accepted) begin
            report_failure("fence ready while loads were outstanding");
            req_valid = 1'b0;
        end else begin
            hold_rsp = 1'b0;
            wait_accept();
        end
        hold_rsp = 1'b0;
        wait_idle();
        end_test("fence");
    endtask

    initial begin
        void'($urandom(76009));
        req_valid  = 1'b0;
        req        = '0;
        rand_mode  = 1'b0;
        hold_rsp   = 1'b0;
        @(negedge clk);
        for (int n = 0; n < TIMEOUT && reset; n++) begin
            @(negedge clk);
        end
        if (reset) begin
            report_failure("reset never released");
        end
        test_reset_idle();
        test_stores();
        test_loads();
        test_partial_masks();
        test_backpressure();
        test_fence();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
lsu_pkg.sv
lsu_addr_gen.sv
lsu_load_queue.sv
lsu_load_format.sv
lsu_commit.sv
lsu_top.sv
lsu_props.sv
tb_clock.sv
lsu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
FAIL_MSG  ?= Done: errors found

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)

run: compile
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
